// ==== sources.f ====
+incdir+include
verilog/hsk_pkg.sv
verilog/hsk_port_decode.sv
verilog/hsk_ctrl_regs.sv
verilog/hsk_packet_buffer.sv
verilog/hsk_wb_ctrl.sv
verilog/hsk_port_top.sv
tb/hsk_port_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := hsk_port_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/hsk_port_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "hsk_defines.svh"

module hsk_port_tb;

    localparam int DRV          = 2;
    localparam int NUM_TXN      = 600;
    // worst case loop body is three port transactions of three cycles
    localparam int PLANNED      = 4 + NUM_TXN * 9 + 200;
    localparam int CYCLE_LIMIT  = 3 * PLANNED;

    logic               wb_clk_i;
    logic               processor_reset;
    hsk_pkg::port_bus_t port_i;
    hsk_pkg::wb_req_t   wb_req_i;
    logic [1:0]         conf_i;
    logic               cratebridge_en_i;
    logic               sda_i;
    logic               scl_i;
    logic [7:0]         in_port_o;
    logic [31:0]        wb_dat_o;
    logic               wb_ack_o;
    logic               cpu_hold_o;
    logic               cratebridge_en_o;
    logic               sda_t_o;
    logic               scl_t_o;

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count;

    // reference model state
    logic [7:0] m_mem [256];
    logic       m_valid [256];
    logic       m_half [2];
    logic       m_hsk_sel;
    logic       m_cb_en;
    logic       m_cb_state;
    logic       m_scl_t;
    logic       m_sda_t;
    logic       m_hold;

    hsk_port_top dut0 (
        .wb_clk_i         (wb_clk_i),
        .processor_reset  (processor_reset),
        .port_i           (port_i),
        .wb_req_i         (wb_req_i),
        .conf_i           (conf_i),
        .cratebridge_en_i (cratebridge_en_i),
        .sda_i            (sda_i),
        .scl_i            (scl_i),
        .in_port_o        (in_port_o),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .cpu_hold_o       (cpu_hold_o),
        .cratebridge_en_o (cratebridge_en_o),
        .sda_t_o          (sda_t_o),
        .scl_t_o          (scl_t_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #20 wb_clk_i = ~wb_clk_i;
    end

    // run limit, independent of the stimulus
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge wb_clk_i);
            cycle_count++;
        end
        $display("timeout: test sequence did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
        end
    endtask

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // k-port ids land on 0x08-0x0f or 0x80-0x87
    function automatic logic [7:0] eff_id(input logic [7:0] id, input logic kport);
        eff_id = kport ? {~id[3], 3'b000, id[3:0]} : id;
    endfunction

    // write target from the port map masks
    function automatic hsk_pkg::port_wr_e write_target(input logic [7:0] eid);
        logic scl;
        logic sda;
        scl = (eid & `HSK_MASK_PAIR_SCL) == `HSK_PORT_SCL;
        sda = (eid & `HSK_MASK_PAIR_SDA) == `HSK_PORT_SDA;
        if (eid[7])
            write_target = hsk_pkg::WR_BUFFER;
        else if (scl && sda)
            write_target = hsk_pkg::WR_SCL_SDA;
        else if (scl)
            write_target = hsk_pkg::WR_SCL;
        else if (sda)
            write_target = hsk_pkg::WR_SDA;
        else if ((eid & `HSK_MASK_PAIR_SDA) == (`HSK_PORT_CTLSTAT & `HSK_MASK_PAIR_SDA))
            write_target = hsk_pkg::WR_CTLSTAT;
        else if ((eid & `HSK_MASK_IDGC) == `HSK_PORT_GENCTL)
            write_target = hsk_pkg::WR_GENCTL;
        else
            write_target = hsk_pkg::WR_NONE;
    endfunction

    // housekeeping area writes one half and reads the other
    function automatic logic [7:0] buf_addr(input logic [7:0] id, input logic bank,
                                            input logic is_write);
        logic half;
        if (id[6])
            half = is_write ? m_hsk_sel : ~m_hsk_sel;
        else
            half = m_half[bank];
        buf_addr = {id[6], half, id[5:0]};
    endfunction

    task automatic model_write(input logic [7:0] id, input logic [7:0] data,
                               input logic kport, input logic bank);
        logic [7:0] eid;
        logic [7:0] addr;
        eid = eff_id(id, kport);
        case (write_target(eid))
            hsk_pkg::WR_BUFFER: begin
                addr          = buf_addr(eid, bank, 1'b1);
                m_mem[addr]   = data;
                m_valid[addr] = 1'b1;
            end
            hsk_pkg::WR_CTLSTAT: m_half[bank] = data[1];
            hsk_pkg::WR_SCL: if (!m_hold) m_scl_t = data[`HSK_SCL_BIT];
            hsk_pkg::WR_SDA: if (!m_hold) m_sda_t = data[`HSK_SDA_BIT];
            hsk_pkg::WR_SCL_SDA: begin
                if (!m_hold) begin
                    m_scl_t = data[`HSK_SCL_BIT];
                    m_sda_t = data[`HSK_SDA_BIT];
                end
            end
            hsk_pkg::WR_GENCTL: begin
                m_hsk_sel = data[0];
                m_cb_en   = data[6];
            end
            default: ;
        endcase
    endtask

    // two cycle write, strobe in the second cycle
    task automatic port_write(input logic [7:0] id, input logic [7:0] data,
                              input logic kport, input logic bank);
        @(posedge wb_clk_i);
        #DRV;
        port_i          = '0;
        port_i.port_id  = id;
        port_i.out_port = data;
        port_i.bank     = bank;
        @(posedge wb_clk_i);
        #DRV;
        if (kport)
            port_i.k_write_strobe = 1'b1;
        else
            port_i.write_strobe = 1'b1;
        @(posedge wb_clk_i);
        #DRV;
        port_i.write_strobe   = 1'b0;
        port_i.k_write_strobe = 1'b0;
        model_write(id, data, kport, bank);
        check_value(32'(scl_t_o), 32'(m_scl_t), "scl_t_o after port write");
        check_value(32'(sda_t_o), 32'(m_sda_t), "sda_t_o after port write");
        check_value(32'(cratebridge_en_o), 32'(m_cb_en), "cratebridge_en_o");
    endtask

    // two cycle read, data taken at the end of the strobe cycle
    task automatic port_read_check(input logic [7:0] id, input logic bank);
        logic [7:0] got;
        logic [7:0] exp;
        logic [7:0] addr;
        logic       known;
        @(posedge wb_clk_i);
        #DRV;
        port_i         = '0;
        port_i.port_id = id;
        port_i.bank    = bank;
        @(posedge wb_clk_i);
        #DRV;
        port_i.read_strobe = 1'b1;
        @(negedge wb_clk_i);
        got = in_port_o;
        @(posedge wb_clk_i);
        #DRV;
        port_i.read_strobe = 1'b0;
        known  = 1'b1;
        exp    = 8'h00;
        // read map: buffer, pins at 0x0c/0x0d, board id at 0x10, general control at 0x11
        if (id[7] || id < 8'h08) begin
            addr  = buf_addr(id, bank, 1'b0);
            known = m_valid[addr];
            exp   = m_mem[addr];
        end else if (id == 8'h0C || id == `HSK_PORT_SCL) begin
            exp[`HSK_SCL_BIT] = scl_i;
            exp[`HSK_SDA_BIT] = sda_i;
        end else if (id == 8'h10) begin
            exp = {`HSK_ID_PREFIX, conf_i, 3'b000};
        end else if (id == `HSK_PORT_GENCTL) begin
            exp = {1'b0, m_cb_state, 5'b00000, m_hsk_sel};
        end
        // unwritten buffer bytes are undefined
        if (known)
            check_value(32'(got), 32'(exp), $sformatf("in_port_o for port 0x%02h", id));
    endtask

    // state must move exactly one edge after the input
    task automatic set_cratebridge(input logic value);
        @(posedge wb_clk_i);
        #DRV;
        port_i           = '0;
        port_i.port_id   = `HSK_PORT_GENCTL;
        cratebridge_en_i = value;
        @(negedge wb_clk_i);
        check_value(32'(in_port_o[6]), 32'(m_cb_state), "crate-bridge state before sync");
        @(posedge wb_clk_i);
        #DRV;
        m_cb_state = value;
        check_value(32'(in_port_o), 32'({1'b0, m_cb_state, 5'b00000, m_hsk_sel}),
                    "port 0x11 after sync");
    endtask

    task automatic wb_access(input logic we, input logic [3:0] sel, input logic [31:0] dat);
        int   lat;
        logic seen;
        @(posedge wb_clk_i);
        #DRV;
        wb_req_i     = '0;
        wb_req_i.cyc = 1'b1;
        wb_req_i.stb = 1'b1;
        wb_req_i.we  = we;
        wb_req_i.sel = sel;
        wb_req_i.dat = dat;
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < 8) begin
            @(posedge wb_clk_i);
            #DRV;
            lat++;
            seen = wb_ack_o;
        end
        if (!seen) begin
            error_count++;
            $display("Wishbone slave never acknowledged the request");
        end
        check_value(32'(lat), 32'd1, "Wishbone ack latency");
        check_value(wb_dat_o, {30'd0, m_cb_state, m_hold}, "wb_dat_o");
        @(posedge wb_clk_i);
        #DRV;
        wb_req_i = '0;
        if (we && sel[0])
            m_hold = dat[0];
        check_value(32'(cpu_hold_o), 32'(m_hold), "cpu_hold_o");
        // ack flop is still set in this cycle, only cyc takes wb_ack_o down
        @(negedge wb_clk_i);
        check_value(32'(wb_ack_o), 32'd0, "wb_ack_o after cyc drops");
        // idle cycle, held pins float
        @(posedge wb_clk_i);
        #DRV;
        if (m_hold) begin
            m_scl_t = 1'b1;
            m_sda_t = 1'b1;
        end
        check_value(32'(scl_t_o), 32'(m_scl_t), "scl_t_o after Wishbone write");
        check_value(32'(sda_t_o), 32'(m_sda_t), "sda_t_o after Wishbone write");
    endtask

    // scl, sda and both pins, plain or k-port
    task automatic random_pin_write();
        logic [31:0] r;
        logic [3:0]  low;
        r   = rand32();
        low = (r[10:9] == 2'd0) ? 4'hD : ((r[10:9] == 2'd1) ? 4'hE : 4'hF);
        port_write(r[8] ? {r[15:12], low} : {4'h0, low}, r[31:24], r[8], r[11]);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        seed             = 32'he4e2_7d2c;
        error_count      = 0;
        check_count      = 0;
        processor_reset  = 1'b1;
        port_i           = '0;
        wb_req_i         = '0;
        conf_i           = 2'b00;
        cratebridge_en_i = 1'b0;
        sda_i            = 1'b1;
        scl_i            = 1'b1;
        for (int i = 0; i < 256; i++) begin
            m_valid[i] = 1'b0;
            m_mem[i]   = 8'h00;
        end
        m_half[0]  = 1'b0;
        m_half[1]  = 1'b0;
        m_hsk_sel  = 1'b0;
        m_cb_en    = 1'b0;
        m_cb_state = 1'b0;
        m_scl_t    = 1'b1;
        m_sda_t    = 1'b1;
        m_hold     = 1'b0;
        repeat (4) @(posedge wb_clk_i);
        #DRV;
        processor_reset = 1'b0;

        // reset values
        check_value(32'(cpu_hold_o), 32'd0, "cpu_hold_o after reset");
        check_value(32'(sda_t_o), 32'd1, "sda_t_o after reset");
        check_value(32'(scl_t_o), 32'd1, "scl_t_o after reset");
        check_value(32'(cratebridge_en_o), 32'd0, "cratebridge_en_o after reset");
        check_value(32'(wb_ack_o), 32'd0, "wb_ack_o after reset");
        port_read_check(`HSK_PORT_GENCTL, 1'b0);

        for (int n = 0; n < NUM_TXN; n++) begin
            r = rand32();
            d = rand32();
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: random_pin_write();
                // narrow id range so reads hit written bytes
                4'd4, 4'd5, 4'd6:
                    port_write(r[8] ? {r[15:12], 1'b0, r[18:16]} :
                               {1'b1, r[20], 3'b000, r[18:16]}, d[7:0], r[8], r[11]);
                4'd7, 4'd8, 4'd9:
                    port_read_check(r[8] ? {5'b00000, r[18:16]} :
                                    {1'b1, r[20], 3'b000, r[18:16]}, r[11]);
                4'd10:
                    port_write(r[8] ? {r[15:12], 3'b101, r[16]} : {7'b0000101, r[16]},
                               d[7:0], r[8], r[11]);
                4'd11: begin
                    port_write(`HSK_PORT_GENCTL, d[7:0], 1'b0, r[11]);
                    conf_i = r[23:22];
                    port_read_check(8'h10, r[11]);
                    port_read_check(`HSK_PORT_GENCTL, r[11]);
                end
                4'd12: set_cratebridge(r[9]);
                4'd13: begin
                    scl_i = r[9];
                    sda_i = r[10];
                    port_read_check(r[8] ? 8'h0D : 8'h0C, r[11]);
                end
                default: wb_access(r[8], r[12:9], {31'd0, d[0] & d[1]});
            endcase
        end

        // pins frozen while the processor is held, sel bit 0 gates the write
        wb_access(1'b1, 4'h1, 32'h1);
        repeat (8) random_pin_write();
        wb_access(1'b1, 4'hE, 32'h0);
        wb_access(1'b0, 4'hF, 32'h0);
        wb_access(1'b1, 4'hF, 32'h0);
        repeat (8) random_pin_write();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/hsk_port_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "hsk_defines.svh"

module hsk_port_top (
    input  logic               wb_clk_i,
    input  logic               processor_reset,
    input  hsk_pkg::port_bus_t port_i,
    input  hsk_pkg::wb_req_t   wb_req_i,
    input  logic [1:0]         conf_i,
    input  logic               cratebridge_en_i,
    input  logic               sda_i,
    input  logic               scl_i,
    output logic [7:0]         in_port_o,
    output logic [31:0]        wb_dat_o,
    output logic               wb_ack_o,
    output logic               cpu_hold_o,
    output logic               cratebridge_en_o,
    output logic               sda_t_o,
    output logic               scl_t_o
);

    hsk_pkg::port_wr_t                   port_wr;
    hsk_pkg::gen_ctl_t                   gen_ctl;
    logic [`HSK_BUF_DEPTH_LOG2-1:0]      buf_addr;
    logic [7:0]                          buf_data;
    logic                                bank_a_half;
    logic                                bank_b_half;
    logic                                cratebridge_state;

    assign cratebridge_en_o = gen_ctl.cratebridge_en;

    // port bus decode and buffer address
    hsk_port_decode u_decode (
        .port_i        (port_i),
        .hsk_sel_i     (gen_ctl.hsk_sel),
        .bank_a_half_i (bank_a_half),
        .bank_b_half_i (bank_b_half),
        .wr_o          (port_wr),
        .buf_addr_o    (buf_addr)
    );

    // registers, pins and the in_port mux
    hsk_ctrl_regs u_regs (
        .wb_clk_i            (wb_clk_i),
        .processor_reset     (processor_reset),
        .wr_i                (port_wr),
        .port_id_i           (port_i.port_id),
        .cpu_hold_i          (cpu_hold_o),
        .conf_i              (conf_i),
        .cratebridge_en_i    (cratebridge_en_i),
        .sda_i               (sda_i),
        .scl_i               (scl_i),
        .buf_data_i          (buf_data),
        .gen_ctl_o           (gen_ctl),
        .bank_a_half_o       (bank_a_half),
        .bank_b_half_o       (bank_b_half),
        .cratebridge_state_o (cratebridge_state),
        .sda_t_o             (sda_t_o),
        .scl_t_o             (scl_t_o),
        .in_port_o           (in_port_o)
    );

    hsk_packet_buffer u_buffer (
        .wb_clk_i  (wb_clk_i),
        .addr_i    (buf_addr),
        .wr_i      (port_wr),
        .rd_data_o (buf_data)
    );

    // wishbone side, holds the softcore in reset
    hsk_wb_ctrl u_wb (
        .wb_clk_i            (wb_clk_i),
        .processor_reset     (processor_reset),
        .wb_req_i            (wb_req_i),
        .cratebridge_state_i (cratebridge_state),
        .wb_dat_o            (wb_dat_o),
        .wb_ack_o            (wb_ack_o),
        .cpu_hold_o          (cpu_hold_o)
    );

endmodule

`default_nettype wire

// ==== verilog/hsk_wb_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module hsk_wb_ctrl (
    input  logic             wb_clk_i,
    input  logic             processor_reset,
    input  hsk_pkg::wb_req_t wb_req_i,
    input  logic             cratebridge_state_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack_o,
    output logic             cpu_hold_o
);

    logic ack;
    logic wr_cycle;

    // write takes effect in the ack cycle
    assign wr_cycle = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && ack;

    // one register, address is not decoded
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset)
            ack <= 1'b0;
        else
            ack <= wb_req_i.cyc && wb_req_i.stb;
    end

    // cpu_hold keeps the softcore in reset, only byte lane 0 counts
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset)
            cpu_hold_o <= 1'b0;
        else if (wr_cycle && wb_req_i.sel[0])
            cpu_hold_o <= wb_req_i.dat[0];
    end

    // drop ack as soon as the master lets go of cyc
    assign wb_ack_o = ack && wb_req_i.cyc;
    assign wb_dat_o = {30'd0, cratebridge_state_i, cpu_hold_o};

endmodule

`default_nettype wire

// ==== verilog/hsk_packet_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "hsk_defines.svh"

module hsk_packet_buffer (
    input  logic                             wb_clk_i,
    input  logic [`HSK_BUF_DEPTH_LOG2-1:0]   addr_i,
    input  hsk_pkg::port_wr_t                wr_i,
    output logic [7:0]                       rd_data_o
);

    localparam int DEPTH = 1 << `HSK_BUF_DEPTH_LOG2;

    // lower half of the address space is the packet area,
    // upper half the housekeeping area, each split in two by the half bit
    logic [7:0] mem [DEPTH];

    logic       wr_en;

    assign wr_en = (wr_i.target == hsk_pkg::WR_BUFFER);

    // single port, old data on a read during write
    always_ff @(posedge wb_clk_i) begin
        if (wr_en)
            mem[addr_i] <= wr_i.data;
    end

    // read every cycle so data is ready by the read strobe cycle
    always_ff @(posedge wb_clk_i) begin
        rd_data_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

// ==== verilog/hsk_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "hsk_defines.svh"

module hsk_ctrl_regs (
    input  logic              wb_clk_i,
    input  logic              processor_reset,
    input  hsk_pkg::port_wr_t wr_i,
    input  logic [7:0]        port_id_i,
    input  logic              cpu_hold_i,
    input  logic [1:0]        conf_i,
    input  logic              cratebridge_en_i,
    input  logic              sda_i,
    input  logic              scl_i,
    input  logic [7:0]        buf_data_i,
    output hsk_pkg::gen_ctl_t gen_ctl_o,
    output logic              bank_a_half_o,
    output logic              bank_b_half_o,
    output logic              cratebridge_state_o,
    output logic              sda_t_o,
    output logic              scl_t_o,
    output logic [7:0]        in_port_o
);

    logic [7:0] id_masked;
    logic [7:0] pin_byte;
    logic [7:0] id_byte;
    logic [7:0] genctl_byte;

    // general control, buffer select in bit 0 and crate bridge enable in bit 6
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            gen_ctl_o <= '0;
        end else if (wr_i.target == hsk_pkg::WR_GENCTL) begin
            gen_ctl_o.hsk_sel        <= wr_i.data[0];
            gen_ctl_o.cratebridge_en <= wr_i.data[6];
        end
    end

    // per-bank packet half, taken from bit 1 of the ctlstat write
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset) begin
            bank_a_half_o <= 1'b0;
            bank_b_half_o <= 1'b0;
        end else if (wr_i.target == hsk_pkg::WR_CTLSTAT) begin
            if (wr_i.bank)
                bank_b_half_o <= wr_i.data[1];
            else
                bank_a_half_o <= wr_i.data[1];
        end
    end

    // crate bridge state comes from outside, one flop of sync
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset)
            cratebridge_state_o <= 1'b0;
        else
            cratebridge_state_o <= cratebridge_en_i;
    end

    // open-drain pins, 1 means released
    always_ff @(posedge wb_clk_i) begin
        if (processor_reset || cpu_hold_i) begin
            // processor held, let both lines float
            sda_t_o <= 1'b1;
            scl_t_o <= 1'b1;
        end else begin
            case (wr_i.target)
                hsk_pkg::WR_SCL: scl_t_o <= wr_i.data[`HSK_SCL_BIT];
                hsk_pkg::WR_SDA: sda_t_o <= wr_i.data[`HSK_SDA_BIT];
                hsk_pkg::WR_SCL_SDA: begin
                    scl_t_o <= wr_i.data[`HSK_SCL_BIT];
                    sda_t_o <= wr_i.data[`HSK_SDA_BIT];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        pin_byte                = 8'h00;
        pin_byte[`HSK_SCL_BIT]  = scl_i;
        pin_byte[`HSK_SDA_BIT]  = sda_i;
    end

    // board id is prefix, conf, then three zeros
    assign id_byte     = {`HSK_ID_PREFIX, conf_i, 3'b000};
    assign genctl_byte = {1'b0, cratebridge_state_o, 5'b00000, gen_ctl_o.hsk_sel};

    // bits 6 and 5 do not take part in the register decode
    assign id_masked = port_id_i & `HSK_MASK_EXACT;

    // read mux, purely from the current port id
    always_comb begin
        in_port_o = 8'h00;
        if (port_id_i[7] || (id_masked[7:3] == 5'b00000))
            in_port_o = buf_data_i;
        else if ((port_id_i & `HSK_MASK_PAIR_SDA) == (`HSK_PORT_SCL & `HSK_MASK_PAIR_SDA))
            // 0x0c and 0x0d both read the pins
            in_port_o = pin_byte;
        else if (id_masked == (`HSK_PORT_GENCTL ^ 8'h01))
            in_port_o = id_byte;
        else if (id_masked == `HSK_PORT_GENCTL)
            in_port_o = genctl_byte;
    end

endmodule

`default_nettype wire

// ==== verilog/hsk_port_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "hsk_defines.svh"

module hsk_port_decode (
    input  hsk_pkg::port_bus_t                port_i,
    input  logic                              hsk_sel_i,
    input  logic                              bank_a_half_i,
    input  logic                              bank_b_half_i,
    output hsk_pkg::port_wr_t                 wr_o,
    output logic [`HSK_BUF_DEPTH_LOG2-1:0]    buf_addr_o
);

    logic [7:0] eff_id;
    logic       any_write;
    logic       scl_hit;
    logic       sda_hit;
    logic       ctlstat_hit;
    logic       genctl_hit;
    logic       packet_half;
    logic       hsk_half;
    logic       half_bit;

    // k-port ids fold down onto 0x08-0x0f or 0x80-0x87
    // inverting bit 3 into bit 7 keeps the low eight ids pointing at the buffer
    assign eff_id = port_i.k_write_strobe ?
                    {~port_i.port_id[3], 3'b000, port_i.port_id[3:0]} :
                    port_i.port_id;

    assign any_write = port_i.write_strobe | port_i.k_write_strobe;

    // masked compares, 0x0f hits both pins at once
    assign scl_hit     = (eff_id & `HSK_MASK_PAIR_SCL) == `HSK_PORT_SCL;
    assign sda_hit     = (eff_id & `HSK_MASK_PAIR_SDA) == `HSK_PORT_SDA;
    assign ctlstat_hit = (eff_id & `HSK_MASK_PAIR_SDA) ==
                         (`HSK_PORT_CTLSTAT & `HSK_MASK_PAIR_SDA);
    assign genctl_hit  = (eff_id & `HSK_MASK_IDGC) == `HSK_PORT_GENCTL;

    always_comb begin
        wr_o.data   = port_i.out_port;
        wr_o.bank   = port_i.bank;
        wr_o.target = hsk_pkg::WR_NONE;
        if (any_write) begin
            // anything with bit 7 set is a buffer write, no further decode
            if (eff_id[7])
                wr_o.target = hsk_pkg::WR_BUFFER;
            else if (scl_hit && sda_hit)
                wr_o.target = hsk_pkg::WR_SCL_SDA;
            else if (scl_hit)
                wr_o.target = hsk_pkg::WR_SCL;
            else if (sda_hit)
                wr_o.target = hsk_pkg::WR_SDA;
            else if (ctlstat_hit)
                wr_o.target = hsk_pkg::WR_CTLSTAT;
            else if (genctl_hit)
                wr_o.target = hsk_pkg::WR_GENCTL;
        end
    end

    // packet area: each processor bank owns its own half select
    assign packet_half = port_i.bank ? bank_b_half_i : bank_a_half_i;
    // housekeeping area: writes go to hsk_sel, reads come from the other half
    assign hsk_half    = any_write ? hsk_sel_i : ~hsk_sel_i;
    assign half_bit    = eff_id[6] ? hsk_half : packet_half;

    // id bit 6 picks packet or housekeeping area, half bit sits just below it
    assign buf_addr_o = {eff_id[6], half_bit, eff_id[5:0]};

endmodule

`default_nettype wire

// ==== verilog/hsk_pkg.sv ====
`default_nettype none

package hsk_pkg;

    // port bus straight from the softcore
    // bank is the register bank the processor is running in
    typedef struct packed {
        logic [7:0] port_id;
        logic [7:0] out_port;
        logic       write_strobe;
        logic       k_write_strobe;
        logic       read_strobe;
        logic       bank;
    } port_bus_t;

    // what a single port write lands on
    typedef enum logic [2:0] {
        WR_NONE,
        WR_BUFFER,
        WR_CTLSTAT,
        WR_SCL,
        WR_SDA,
        WR_SCL_SDA,
        WR_GENCTL
    } port_wr_e;

    // classified write, data is out_port of the same cycle
    typedef struct packed {
        port_wr_e   target;
        logic [7:0] data;
        logic       bank;
    } port_wr_t;

    // general control register contents
    typedef struct packed {
        logic hsk_sel;
        logic cratebridge_en;
    } gen_ctl_t;

    // wishbone request side, 12 bit address and 32 bit data
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [11:0] adr;
        logic [31:0] dat;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== include/hsk_defines.svh ====
`ifndef HSK_DEFINES_SVH
`define HSK_DEFINES_SVH

// port map seen by the softcore
// 0x00 - 0x07 buffer alias, kept free so k-port writes can reach the buffer
// 0x0c - 0x0f i2c pins
// 0x10 board id, 0x11 general control
// 0x80 - 0xff packet and housekeeping buffer
`define HSK_PORT_CTLSTAT 8'h0B
`define HSK_PORT_SCL 8'h0D
`define HSK_PORT_SDA 8'h0E
`define HSK_PORT_GENCTL 8'h11

// only bits 7 and 4..0 take part in the decode
`define HSK_MASK_EXACT 8'h9F
// scl write hits 0x0d and 0x0f
`define HSK_MASK_PAIR_SCL 8'h9D
// sda write hits 0x0e and 0x0f, ctlstat hits 0x0a and 0x0b
`define HSK_MASK_PAIR_SDA 8'h9E
// bit 0 splits board id (even) from general control (odd)
`define HSK_MASK_IDGC 8'h91

// top three bits of the board id, conf sits below them
`define HSK_ID_PREFIX 3'b010

// 256 byte buffer
`define HSK_BUF_DEPTH_LOG2 8

// pin positions in out_port and in the pin read-back byte
`define HSK_SCL_BIT 1
`define HSK_SDA_BIT 0

`endif
